//--- source/immu_spr_pkg.sv
// SPR bus address map and region encoding for the instruction TLB
package immu_spr_pkg;

   // SPR address width on the bus
   localparam int spr_addr_w = 16;

   // ITLB way 0 window in the SPR space
   localparam logic [spr_addr_w-1:0] itlb_mr_base = 16'h1200; // First match register
   localparam logic [spr_addr_w-1:0] itlb_tr_base = 16'h1280; // First translate register
   localparam logic [spr_addr_w-1:0] itlb_end     = 16'h1300; // One past last translate reg

   // Match window runs mr_base up to tr_base
   // Translate window runs tr_base up to itlb_end
   // Only the low index bits select the entry, the rest of each window aliases

   // Which table an SPR address lands in
   typedef enum logic [1:0] {
      ITLB_NONE,  // Outside the ITLB map, reads as zero
      ITLB_MATCH, // Match table (VPN and valid)
      ITLB_TRANS  // Translate table (PPN and attributes)
   } spr_region_e;

endpackage

//--- source/immu_tlb_pkg.sv
// Page geometry, TLB entry layout and fault codes for the instruction MMU
package immu_tlb_pkg;

   localparam int data_w    = 32; // Address and entry width
   localparam int page_bits = 13; // 8 KB pages, offset is vaddr[12:0]
   localparam int set_w     = 6;  // 64 sets, index is vaddr[18:13]

   // Match entry
   localparam int valid_bit = 0;

   // Translate entry
   localparam int ci_bit  = 1; // Cache inhibit
   localparam int sxe_bit = 6; // Supervisor execute enable
   localparam int uxe_bit = 7; // User execute enable

   // Page number sits in [data_w-1:page_bits] of both entries

   // Result of one translation
   typedef enum logic [1:0] {
      FAULT_NONE,     // Hit with execute permission
      FAULT_TLB_MISS, // Invalid entry or tag mismatch
      FAULT_PAGE      // Hit but execute not allowed in this mode
   } fault_e;

endpackage

//--- source/itlb_spr_if.sv
// SPR side table port between the bus decoder and the TLB tables
`timescale 1ns/1ps

interface itlb_spr_if;

   logic                              match_we;    // Match table write strobe
   logic                              trans_we;    // Translate table write strobe
   logic [immu_tlb_pkg::set_w-1:0]    index;       // Entry select
   logic [immu_tlb_pkg::data_w-1:0]   wdata;       // Shared write data
   logic [immu_tlb_pkg::data_w-1:0]   match_rdata; // Registered, one cycle after index
   logic [immu_tlb_pkg::data_w-1:0]   trans_rdata; // Registered, one cycle after index

   // Bus decoder side
   modport decoder (
      output match_we,
      output trans_we,
      output index,
      output wdata,
      input  match_rdata,
      input  trans_rdata
   );

   // Table owner side
   modport tables (
      input  match_we,
      input  trans_we,
      input  index,
      input  wdata,
      output match_rdata,
      output trans_rdata
   );

endinterface

//--- source/spr_bus_decode.sv
// Decodes SPR bus accesses into ITLB table writes, acknowledge and read-back
`timescale 1ns/1ps

module spr_bus_decode (
   input  logic                                clk,
   input  logic                                rst,
   input  logic                                spr_stb_i,
   input  logic                                spr_we_i,
   input  logic [immu_spr_pkg::spr_addr_w-1:0] spr_addr_i,
   input  logic [immu_tlb_pkg::data_w-1:0]     spr_dat_i,
   output logic [immu_tlb_pkg::data_w-1:0]     spr_dat_o,
   output logic                                spr_ack_o,
   itlb_spr_if.decoder                         spr_o
);

   immu_spr_pkg::spr_region_e region;   // Region of the current address
   immu_spr_pkg::spr_region_e region_q; // Region of the access being acked
   logic                      ack_q;

   // Address window decode
   always_comb begin
      region = immu_spr_pkg::ITLB_NONE;
      if (spr_addr_i >= immu_spr_pkg::itlb_mr_base &&
          spr_addr_i <  immu_spr_pkg::itlb_tr_base) begin
         region = immu_spr_pkg::ITLB_MATCH;
      end else if (spr_addr_i >= immu_spr_pkg::itlb_tr_base &&
                   spr_addr_i <  immu_spr_pkg::itlb_end) begin
         region = immu_spr_pkg::ITLB_TRANS;
      end
   end

   // Table port, writes land on the strobe edge
   assign spr_o.index    = spr_addr_i[immu_tlb_pkg::set_w-1:0]; // Low bits pick the entry
   assign spr_o.wdata    = spr_dat_i;
   assign spr_o.match_we = spr_stb_i & spr_we_i & (region == immu_spr_pkg::ITLB_MATCH);
   assign spr_o.trans_we = spr_stb_i & spr_we_i & (region == immu_spr_pkg::ITLB_TRANS);

   // One ack pulse per strobe, region kept for the read mux
   always_ff @(posedge clk) begin
      if (rst) begin
         ack_q    <= 1'b0;
         region_q <= immu_spr_pkg::ITLB_NONE;
      end else begin
         ack_q    <= spr_stb_i & ~ack_q; // Single pulse even if strobe lingers
         region_q <= spr_stb_i ? region : immu_spr_pkg::ITLB_NONE;
      end
   end

   assign spr_ack_o = ack_q;

   // Read-back lines up with the registered table data
   always_comb begin
      case (region_q)
         immu_spr_pkg::ITLB_MATCH: spr_dat_o = spr_o.match_rdata;
         immu_spr_pkg::ITLB_TRANS: spr_dat_o = spr_o.trans_rdata;
         default:                  spr_dat_o = '0; // Out of map reads as zero
      endcase
   end

endmodule

//--- source/itlb_dpram.sv
// Single clock true dual-port RAM, read-only lookup port A and read-first port B
`timescale 1ns/1ps

module itlb_dpram #(
   parameter int addr_w = immu_tlb_pkg::set_w,
   parameter int data_w = immu_tlb_pkg::data_w
) (
   input  logic              clk,
   // Port A, lookup
   input  logic [addr_w-1:0] addr_a_i,
   input  logic              en_a_i,
   output logic [data_w-1:0] dout_a_o,
   // Port B, SPR access
   input  logic [addr_w-1:0] addr_b_i,
   input  logic              we_b_i,
   input  logic [data_w-1:0] din_b_i,
   output logic [data_w-1:0] dout_b_o
);

   logic [data_w-1:0] mem [2**addr_w];

   // Port A holds its output while disabled
   always_ff @(posedge clk) begin
      if (en_a_i) begin
         dout_a_o <= mem[addr_a_i];
      end
   end

   // Port B returns the old word on a write
   always_ff @(posedge clk) begin
      if (we_b_i) begin
         mem[addr_b_i] <= din_b_i;
      end
      dout_b_o <= mem[addr_b_i]; // Read-first
   end

endmodule

//--- source/itlb_lookup.sv
// ITLB request stage, owns both tables and reads the indexed set per request
`timescale 1ns/1ps

module itlb_lookup (
   input  logic                            clk,
   input  logic                            rst,
   // Request in
   input  logic                            req_valid_i,
   output logic                            req_ready_o,
   input  logic [immu_tlb_pkg::data_w-1:0] req_vaddr_i,
   input  logic                            req_supervisor_i,
   // SPR table port
   itlb_spr_if.tables                      spr_i,
   // Towards the result stage
   output logic                            stage_valid_o,
   input  logic                            stall_i,
   output logic [immu_tlb_pkg::data_w-1:0] stage_vaddr_o,
   output logic                            stage_supervisor_o,
   output logic [immu_tlb_pkg::data_w-1:0] match_word_o,
   output logic [immu_tlb_pkg::data_w-1:0] trans_word_o
);

   logic                           valid_q;
   logic                           accept;
   logic [immu_tlb_pkg::set_w-1:0] set_idx;

   assign req_ready_o = ~valid_q | ~stall_i; // Empty or moving on
   assign accept      = req_valid_i & req_ready_o;
   assign set_idx     = req_vaddr_i[immu_tlb_pkg::page_bits +: immu_tlb_pkg::set_w];

   always_ff @(posedge clk) begin
      if (rst) begin
         valid_q <= 1'b0;
      end else if (req_ready_o) begin
         valid_q <= req_valid_i; // Refill or drain
      end
   end

   // Request fields ride beside the RAM read
   always_ff @(posedge clk) begin
      if (accept) begin
         stage_vaddr_o      <= req_vaddr_i;
         stage_supervisor_o <= req_supervisor_i;
      end
   end

   assign stage_valid_o = valid_q;

   // VPN and valid bit
   itlb_dpram match_ram (
      .clk      (clk),
      .addr_a_i (set_idx),
      .en_a_i   (accept), // Held while stalled
      .dout_a_o (match_word_o),
      .addr_b_i (spr_i.index),
      .we_b_i   (spr_i.match_we),
      .din_b_i  (spr_i.wdata),
      .dout_b_o (spr_i.match_rdata)
   );

   // PPN and attributes
   itlb_dpram trans_ram (
      .clk      (clk),
      .addr_a_i (set_idx),
      .en_a_i   (accept),
      .dout_a_o (trans_word_o),
      .addr_b_i (spr_i.index),
      .we_b_i   (spr_i.trans_we),
      .din_b_i  (spr_i.wdata),
      .dout_b_o (spr_i.trans_rdata)
   );

endmodule

//--- source/immu_result.sv
// ITLB result stage, tag compare, execute check and response register
`timescale 1ns/1ps

module immu_result (
   input  logic                            clk,
   input  logic                            rst,
   // From the lookup stage
   input  logic                            stage_valid_i,
   output logic                            stall_o,
   input  logic [immu_tlb_pkg::data_w-1:0] stage_vaddr_i,
   input  logic                            stage_supervisor_i,
   input  logic [immu_tlb_pkg::data_w-1:0] match_word_i,
   input  logic [immu_tlb_pkg::data_w-1:0] trans_word_i,
   // Response out
   output logic                            rsp_valid_o,
   input  logic                            rsp_ready_i,
   output logic [immu_tlb_pkg::data_w-1:0] rsp_paddr_o,
   output logic                            rsp_cache_inhibit_o,
   output immu_tlb_pkg::fault_e            rsp_fault_o
);

   localparam int pg = immu_tlb_pkg::page_bits;
   localparam int dw = immu_tlb_pkg::data_w;

   logic                 miss;
   logic                 exec_ok;
   immu_tlb_pkg::fault_e fault;

   // Invalid entry or VPN mismatch
   assign miss = ~match_word_i[immu_tlb_pkg::valid_bit] |
                 (match_word_i[dw-1:pg] != stage_vaddr_i[dw-1:pg]);

   assign exec_ok = stage_supervisor_i ? trans_word_i[immu_tlb_pkg::sxe_bit]
                                       : trans_word_i[immu_tlb_pkg::uxe_bit];

   always_comb begin
      if (miss) begin
         fault = immu_tlb_pkg::FAULT_TLB_MISS; // Miss wins over permissions
      end else if (!exec_ok) begin
         fault = immu_tlb_pkg::FAULT_PAGE;
      end else begin
         fault = immu_tlb_pkg::FAULT_NONE;
      end
   end

   assign stall_o = rsp_valid_o & ~rsp_ready_i; // Full and not retiring

   always_ff @(posedge clk) begin
      if (rst) begin
         rsp_valid_o <= 1'b0;
      end else if (!stall_o) begin
         rsp_valid_o <= stage_valid_i;
      end
   end

   // Payload held steady under back-pressure
   always_ff @(posedge clk) begin
      if (!stall_o && stage_valid_i) begin
         rsp_paddr_o         <= {trans_word_i[dw-1:pg], stage_vaddr_i[pg-1:0]};
         rsp_cache_inhibit_o <= trans_word_i[immu_tlb_pkg::ci_bit];
         rsp_fault_o         <= fault;
      end
   end

endmodule

//--- source/immu_top.sv
// Instruction MMU top, SPR decoder plus two-stage ITLB translation pipeline
`timescale 1ns/1ps

module immu_top (
   input  logic                                clk,
   input  logic                                rst,
   // SPR bus
   input  logic                                spr_stb_i,
   input  logic                                spr_we_i,
   input  logic [immu_spr_pkg::spr_addr_w-1:0] spr_addr_i,
   input  logic [immu_tlb_pkg::data_w-1:0]     spr_dat_i,
   output logic [immu_tlb_pkg::data_w-1:0]     spr_dat_o,
   output logic                                spr_ack_o,
   // Translation request
   input  logic                                req_valid_i,
   output logic                                req_ready_o,
   input  logic [immu_tlb_pkg::data_w-1:0]     req_vaddr_i,
   input  logic                                req_supervisor_i,
   // Translation response
   output logic                                rsp_valid_o,
   input  logic                                rsp_ready_i,
   output logic [immu_tlb_pkg::data_w-1:0]     rsp_paddr_o,
   output logic                                rsp_cache_inhibit_o,
   output immu_tlb_pkg::fault_e                rsp_fault_o
);

   logic                            stage_valid;
   logic                            stall;
   logic [immu_tlb_pkg::data_w-1:0] stage_vaddr;
   logic                            stage_supervisor;
   logic [immu_tlb_pkg::data_w-1:0] match_word;
   logic [immu_tlb_pkg::data_w-1:0] trans_word;

   itlb_spr_if spr_if ();

   spr_bus_decode decode_i (
      .clk        (clk),
      .rst        (rst),
      .spr_stb_i  (spr_stb_i),
      .spr_we_i   (spr_we_i),
      .spr_addr_i (spr_addr_i),
      .spr_dat_i  (spr_dat_i),
      .spr_dat_o  (spr_dat_o),
      .spr_ack_o  (spr_ack_o),
      .spr_o      (spr_if.decoder)
   );

   itlb_lookup lookup_i (
      .clk                (clk),
      .rst                (rst),
      .req_valid_i        (req_valid_i),
      .req_ready_o        (req_ready_o),
      .req_vaddr_i        (req_vaddr_i),
      .req_supervisor_i   (req_supervisor_i),
      .spr_i              (spr_if.tables),
      .stage_valid_o      (stage_valid),
      .stall_i            (stall),
      .stage_vaddr_o      (stage_vaddr),
      .stage_supervisor_o (stage_supervisor),
      .match_word_o       (match_word),
      .trans_word_o       (trans_word)
   );

   immu_result result_i (
      .clk                 (clk),
      .rst                 (rst),
      .stage_valid_i       (stage_valid),
      .stall_o             (stall),
      .stage_vaddr_i       (stage_vaddr),
      .stage_supervisor_i  (stage_supervisor),
      .match_word_i        (match_word),
      .trans_word_i        (trans_word),
      .rsp_valid_o         (rsp_valid_o),
      .rsp_ready_i         (rsp_ready_i),
      .rsp_paddr_o         (rsp_paddr_o),
      .rsp_cache_inhibit_o (rsp_cache_inhibit_o),
      .rsp_fault_o         (rsp_fault_o)
   );

endmodule

//--- testbench/immu_assertions.sv
// Protocol assertions on the instruction MMU top level ports
`timescale 1ns/1ps

module immu_assertions (
   input logic                            clk,
   input logic                            rst,
   input logic                            spr_stb_i,
   input logic                            spr_ack_o,
   input logic                            rsp_valid_o,
   input logic                            rsp_ready_i,
   input logic [immu_tlb_pkg::data_w-1:0] rsp_paddr_o,
   input logic                            rsp_cache_inhibit_o,
   input immu_tlb_pkg::fault_e            rsp_fault_o
);

   // Fresh strobe gets its ack one cycle later
   ack_after_stb: assert property (@(posedge clk) disable iff (rst)
      spr_stb_i && !spr_ack_o |=> spr_ack_o)
      else $error("spr_ack_o missing one cycle after spr_stb_i");

   ack_single_pulse: assert property (@(posedge clk) disable iff (rst)
      spr_ack_o |=> !spr_ack_o)
      else $error("spr_ack_o high for more than one cycle");

   // Held response under back-pressure
   rsp_stable: assert property (@(posedge clk) disable iff (rst)
      rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_paddr_o) &&
      $stable(rsp_cache_inhibit_o) && $stable(rsp_fault_o))
      else $error("Response changed while stalled");

   valid_low_after_rst: assert property (@(posedge clk)
      rst |=> !rsp_valid_o && !spr_ack_o)
      else $error("Valid or ack high after reset");

endmodule

//--- testbench/immu_tb.sv
// Directed testbench for the instruction MMU with a reference copy of both ITLB tables
`timescale 1ns/1ps

module immu_tb;

   localparam int timeout = 50; // Cycles allowed per wait

   logic                 clk = 1'b0;
   logic                 rst;
   logic                 spr_stb_i, spr_we_i, spr_ack_o;
   logic [15:0]          spr_addr_i;
   logic [31:0]          spr_dat_i, spr_dat_o;
   logic                 req_valid_i, req_ready_o, req_supervisor_i;
   logic [31:0]          req_vaddr_i;
   logic                 rsp_valid_o, rsp_ready_i, rsp_cache_inhibit_o;
   logic [31:0]          rsp_paddr_o;
   immu_tlb_pkg::fault_e rsp_fault_o;

   logic [31:0] match_m [64]; // Model of the match table
   logic [31:0] trans_m [64]; // Model of the translate table
   integer      seed = 32'h1dcb;

   always #4 clk = ~clk; // 8 ns period

   immu_top dut_i (.*);

   bind immu_top immu_assertions assertions_i (
      .clk (clk), .rst (rst), .spr_stb_i (spr_stb_i), .spr_ack_o (spr_ack_o),
      .rsp_valid_o (rsp_valid_o), .rsp_ready_i (rsp_ready_i), .rsp_paddr_o (rsp_paddr_o),
      .rsp_cache_inhibit_o (rsp_cache_inhibit_o), .rsp_fault_o (rsp_fault_o)
   );

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("Some tests failed");
      $fatal(1, "Run stopped at first error");
   endtask

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         fail_run($sformatf("CHECK FAILED at time %0t: %s is %h, expected %h",
                            $time, name, got, exp));
      end
   endtask

   task automatic next_cycle;
      @(posedge clk);
      #1; // Drive point
   endtask

   // Strobe held until ack and ack must be a single pulse
   task automatic spr_access(input logic we, input logic [15:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
      int n;
      next_cycle();
      spr_stb_i  = 1'b1;
      spr_we_i   = we;
      spr_addr_i = addr;
      spr_dat_i  = wdata;
      n = 0;
      @(negedge clk);
      while (!spr_ack_o) begin
         n++;
         if (n > timeout) fail_run("SPR access was never acknowledged");
         @(negedge clk);
      end
      check("spr_ack_o delay in cycles", n, 1);
      rdata = spr_dat_o; // Valid in the ack cycle
      next_cycle();
      spr_stb_i = 1'b0;
      spr_we_i  = 1'b0;
      @(negedge clk);
      check("spr_ack_o after pulse", 32'(spr_ack_o), 0);
   endtask

   task automatic spr_write(input logic [15:0] addr, input logic [31:0] data);
      logic [31:0] unused;
      spr_access(1'b1, addr, data, unused);
      if (addr >= immu_spr_pkg::itlb_mr_base && addr < immu_spr_pkg::itlb_tr_base)
         match_m[addr[5:0]] = data;
      else if (addr >= immu_spr_pkg::itlb_tr_base && addr < immu_spr_pkg::itlb_end)
         trans_m[addr[5:0]] = data;
   endtask

   task automatic spr_read(input logic [15:0] addr, input logic [31:0] exp);
      logic [31:0] data;
      spr_access(1'b0, addr, 32'h0, data);
      check("spr_dat_o", data, exp);
   endtask

   // Match word gets the page number of va plus the valid bit
   task automatic fill(input logic [31:0] va, input logic valid, input logic [31:0] tw);
      spr_write(immu_spr_pkg::itlb_mr_base | {10'b0, va[18:13]}, {va[31:13], 12'h0, valid});
      spr_write(immu_spr_pkg::itlb_tr_base | {10'b0, va[18:13]}, tw);
   endtask

   // Miss checked before the execute enable of the mode
   function automatic immu_tlb_pkg::fault_e predict(input logic [31:0] va, input logic sup);
      logic [31:0] mw;
      logic [31:0] tw;
      mw = match_m[va[18:13]];
      tw = trans_m[va[18:13]];
      if (!mw[0] || mw[31:13] != va[31:13]) return immu_tlb_pkg::FAULT_TLB_MISS;
      if (!(sup ? tw[6] : tw[7])) return immu_tlb_pkg::FAULT_PAGE; // sxe bit 6, uxe bit 7
      return immu_tlb_pkg::FAULT_NONE;
   endfunction

   // One request on an idle pipeline
   task automatic translate(input logic [31:0] va, input logic sup,
                            input immu_tlb_pkg::fault_e exp);
      int edges;
      next_cycle();
      req_valid_i      = 1'b1;
      req_vaddr_i      = va;
      req_supervisor_i = sup;
      rsp_ready_i      = 1'b1;
      edges = 0;
      @(negedge clk);
      while (!req_ready_o) begin
         edges++;
         if (edges > timeout) fail_run("Request was never accepted");
         @(negedge clk);
      end
      next_cycle(); // Accept edge just passed
      req_valid_i = 1'b0;
      edges = 1;
      @(negedge clk);
      while (!rsp_valid_o) begin
         edges++;
         if (edges > timeout) fail_run("No response arrived for the request");
         @(negedge clk);
      end
      check("response edges after accept", edges, 2);
      check("rsp_fault_o", 32'(rsp_fault_o), 32'(exp));
      check("rsp_fault_o from model", 32'(rsp_fault_o), 32'(predict(va, sup)));
      check("rsp_paddr_o", rsp_paddr_o, {trans_m[va[18:13]][31:13], va[12:0]});
      check("rsp_cache_inhibit_o", 32'(rsp_cache_inhibit_o), 32'(trans_m[va[18:13]][1]));
   endtask

   task automatic spr_roundtrip;
      spr_write(immu_spr_pkg::itlb_mr_base | 16'd3, 32'h1234_6001);
      spr_write(immu_spr_pkg::itlb_tr_base | 16'd3, 32'h8765_40c2);
      spr_write(immu_spr_pkg::itlb_mr_base | 16'd63, 32'hffff_e000);
      spr_read(immu_spr_pkg::itlb_mr_base | 16'd3, 32'h1234_6001);
      spr_read(immu_spr_pkg::itlb_tr_base | 16'd3, 32'h8765_40c2);
      spr_read(immu_spr_pkg::itlb_mr_base | 16'd63, 32'hffff_e000);
      spr_read(16'h0600, 32'h0);                 // Below the ITLB window
      spr_read(immu_spr_pkg::itlb_end, 32'h0);   // Just past it
   endtask

   task automatic hit_paths;
      fill(32'h0040_a000, 1'b1, 32'h7f00_20c2); // Set 5 cache inhibited
      fill(32'h0040_c000, 1'b1, 32'h0123_40c0); // Set 6 cacheable
      translate(32'h0040_b234, 1'b0, immu_tlb_pkg::FAULT_NONE);
      translate(32'h0040_a001, 1'b1, immu_tlb_pkg::FAULT_NONE);
      translate(32'h0040_dffc, 1'b1, immu_tlb_pkg::FAULT_NONE);
   endtask

   task automatic miss_cases;
      fill(32'h0041_2000, 1'b0, 32'h0456_00c0); // Set 9 invalid
      fill(32'h0041_4000, 1'b1, 32'h0567_00c0); // Set 10
      fill(32'h0041_6000, 1'b0, 32'h0678_0000); // Set 11 invalid and no execute
      translate(32'h0041_2010, 1'b1, immu_tlb_pkg::FAULT_TLB_MISS);
      translate(32'h0081_4010, 1'b1, immu_tlb_pkg::FAULT_TLB_MISS); // Other tag
      translate(32'h0041_6020, 1'b0, immu_tlb_pkg::FAULT_TLB_MISS); // Miss over page fault
   endtask

   task automatic exec_permissions;
      fill(32'h0041_8000, 1'b1, 32'h0222_2040); // Set 12 sxe only
      fill(32'h0041_a000, 1'b1, 32'h0333_2080); // Set 13 uxe only
      translate(32'h0041_8100, 1'b0, immu_tlb_pkg::FAULT_PAGE);
      translate(32'h0041_8100, 1'b1, immu_tlb_pkg::FAULT_NONE);
      translate(32'h0041_a100, 1'b0, immu_tlb_pkg::FAULT_NONE);
      translate(32'h0041_a100, 1'b1, immu_tlb_pkg::FAULT_PAGE);
   endtask

   // Back to back requests with random back-pressure
   task automatic backpressure_stream;
      logic [31:0]          r, t, last_pa;
      logic [31:0]          pa_q [$];
      logic                 ci_q [$];
      immu_tlb_pkg::fault_e f_q [$];
      immu_tlb_pkg::fault_e last_f;
      logic [5:0]           s;
      logic                 held, stalled, last_ci;
      int                   i, sent, got, cycles;
      for (i = 16; i < 24; i++) begin
         r = $random(seed);
         fill({r[31:19], 6'(i), 13'h0}, 1'b1, $random(seed));
      end
      sent = 0;
      got = 0;
      cycles = 0;
      held = 1'b0;
      stalled = 1'b0;
      while (got < 40) begin
         next_cycle();
         cycles++;
         if (cycles > 400) fail_run("Request stream did not drain");
         if (!held && sent < 40) begin
            r = $random(seed);
            s = {3'b010, r[2:0]};                    // Sets 16 to 23
            req_vaddr_i = {match_m[s][31:19] ^ {12'h0, r[4:3] == 2'b00}, s, r[17:5]};
            req_supervisor_i = r[18];
         end
         req_valid_i = sent < 40;
         t = $random(seed);
         rsp_ready_i = t[0];
         @(negedge clk);
         if (stalled) begin
            check("rsp_valid_o while stalled", 32'(rsp_valid_o), 1);
            check("rsp_paddr_o while stalled", rsp_paddr_o, last_pa);
            check("rsp_cache_inhibit_o while stalled", 32'(rsp_cache_inhibit_o), 32'(last_ci));
            check("rsp_fault_o while stalled", 32'(rsp_fault_o), 32'(last_f));
         end
         if (req_valid_i && req_ready_o) begin
            pa_q.push_back({trans_m[req_vaddr_i[18:13]][31:13], req_vaddr_i[12:0]});
            ci_q.push_back(trans_m[req_vaddr_i[18:13]][1]);
            f_q.push_back(predict(req_vaddr_i, req_supervisor_i));
            sent++;
         end
         held = req_valid_i && !req_ready_o; // Same request again next cycle
         if (rsp_valid_o && rsp_ready_i) begin
            if (pa_q.size() == 0) fail_run("Response arrived without a request");
            check("stream rsp_paddr_o", rsp_paddr_o, pa_q.pop_front());
            check("stream rsp_cache_inhibit_o", 32'(rsp_cache_inhibit_o), 32'(ci_q.pop_front()));
            check("stream rsp_fault_o", 32'(rsp_fault_o), 32'(f_q.pop_front()));
            got++;
         end
         stalled = rsp_valid_o && !rsp_ready_i;
         last_pa = rsp_paddr_o;
         last_ci = rsp_cache_inhibit_o;
         last_f  = rsp_fault_o;
      end
      next_cycle();
      req_valid_i = 1'b0;
      rsp_ready_i = 1'b1;
      @(negedge clk);
      check("rsp_valid_o after stream", 32'(rsp_valid_o), 0); // No extra response
   endtask

   initial begin
      rst              = 1'b1;
      spr_stb_i        = 1'b0;
      spr_we_i         = 1'b0;
      spr_addr_i       = 16'h0;
      spr_dat_i        = 32'h0;
      req_valid_i      = 1'b0;
      req_vaddr_i      = 32'h0;
      req_supervisor_i = 1'b0;
      rsp_ready_i      = 1'b1;
      repeat (3) @(posedge clk);
      #1;
      rst = 1'b0;
      @(negedge clk);
      check("rsp_valid_o after reset", 32'(rsp_valid_o), 0);
      check("spr_ack_o after reset", 32'(spr_ack_o), 0);
      check("req_ready_o after reset", 32'(req_ready_o), 1);
      spr_roundtrip();
      hit_paths();
      miss_cases();
      exec_permissions();
      backpressure_stream();
      $display("All tests passed");
      $finish;
   end

endmodule

//--- vlog.f
source/immu_spr_pkg.sv
source/immu_tlb_pkg.sv
source/itlb_spr_if.sv
source/spr_bus_decode.sv
source/itlb_dpram.sv
source/itlb_lookup.sv
source/immu_result.sv
source/immu_top.sv
testbench/immu_assertions.sv
testbench/immu_tb.sv

//--- Makefile
# Verilator build and run of the instruction MMU testbench

VERILATOR ?= verilator
TOP       ?= immu_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
SIM_ARGS  ?=

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Exit status of the simulator is the result
run: compile
	./$(SIM_BIN) $(SIM_ARGS)

clean:
	rm -rf $(OBJ_DIR)
